// ==== design/audioPkg.sv ====
// Audio sample player shared definitions
// Widths, APB register map, DAC frame format and bus structs
package audioPkg;

	typedef logic [7:0] sampleT; // One audio sample
	typedef logic [7:0] romAddrT;
	typedef logic [15:0] rateDivT; // Tick period minus one
	typedef logic [15:0] dacFrameT; // One SPI word to the DAC
	typedef logic [7:0] apbAddrT; // Byte address
	typedef logic [31:0] apbDataT;

	typedef struct packed {
		logic valid; // Held until the response arrives
		romAddrT address;
	} romReqT;

	typedef struct packed {
		logic valid; // One cycle only
		sampleT data;
	} romRspT;

	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		apbAddrT paddr;
		apbDataT pwdata;
	} apbReqT;

	typedef struct packed {
		logic pready;
		apbDataT prdata;
		logic pslverr;
	} apbRspT;

	typedef struct packed {
		logic sclk;
		logic syncN; // Low while a frame is sent
		logic din;
	} spiPinsT;

	// Register map
	localparam apbAddrT regCtrl = 8'h00; // Bit 0 enable
	localparam apbAddrT regRate = 8'h04;
	localparam apbAddrT regStart = 8'h08;
	localparam apbAddrT regEnd = 8'h0C;
	localparam apbAddrT regStatus = 8'h10; // Playing, current address, frame count
	localparam apbAddrT regRomWindow = 8'h20; // Read-only, one ROM word per 4 bytes

	localparam logic [3:0] frameCtrlBits = 4'b0000; // DAC control nibble
	localparam logic [3:0] framePadBits = 4'b0000;
	localparam int sclkHalfPeriod = 2; // 12.5 MHz SCLK
	localparam int sclkCntWidth = $clog2(sclkHalfPeriod) + 1;
	localparam rateDivT defaultRateDiv = 16'd1041; // About 48 kHz
	localparam int romDepth = 256;

	// Triangle wave, rising over the lower half and falling over the upper half
	function automatic sampleT triangleSample(romAddrT a);
		if (a < 8'd128)
			return sampleT'({a[6:0], 1'b0});
		return sampleT'({~a[6:0], 1'b0}); // 2*(255-a)
	endfunction

endpackage

// ==== design/sampleRateTimer.sv ====
// Sample rate timer
// Down-counter that pulses tick for one cycle every rateDiv+1 cycles
`timescale 1ns/1ps

module sampleRateTimer (
	input logic max10Board_50MhzClock,
	input logic reset,
	input logic enable,
	input audioPkg::rateDivT rateDiv,
	output logic tick
);
	import audioPkg::*;

	rateDivT count; // Cycles left until the next tick

	always_ff @(posedge max10Board_50MhzClock)
	begin
		if (reset || !enable)
		begin
			// Reloaded while stopped, so the first period is a full one
			count <= rateDiv;
			tick <= 1'b0;
		end
		else if (count == '0)
		begin
			count <= rateDiv; // Reload
			tick <= 1'b1;
		end
		else
		begin
			count <= count - 1'b1;
			tick <= 1'b0;
		end
	end

endmodule

// ==== design/sampleRom.sv ====
// Sample ROM
// 256 x 8 triangle table with a registered output, built at elaboration
// Infers an M9K block on the MAX10
`timescale 1ns/1ps

module sampleRom (
	input logic max10Board_50MhzClock,
	input audioPkg::romAddrT address,
	output audioPkg::sampleT data
);
	import audioPkg::*;

	sampleT romArray [romDepth];

	// Table contents
	initial
	begin
		for (int i = 0; i < romDepth; i++)
		begin
			romArray[i] = triangleSample(romAddrT'(i));
		end
	end

	// One cycle read latency
	always_ff @(posedge max10Board_50MhzClock)
	begin
		data <= romArray[address];
	end

endmodule

// ==== design/romArbiter.sv ====
// ROM arbiter
// Shares the sample ROM between the playback sequencer and the host
// Sequencer has fixed priority, one grant per cycle
`timescale 1ns/1ps

module romArbiter (
	input logic max10Board_50MhzClock,
	input logic reset,
	input audioPkg::romReqT playReq,
	input audioPkg::romReqT hostReq,
	output audioPkg::romRspT playRsp,
	output audioPkg::romRspT hostRsp,
	output audioPkg::romAddrT romAddress,
	input audioPkg::sampleT romData
);

	logic grantPlay;
	logic grantHost;
	logic lastValid; // A grant was made last cycle
	logic lastHost; // That grant went to the host

	// Data from the registered ROM belongs to last cycle's grant
	always_comb
	begin
		playRsp.valid = lastValid && !lastHost;
		playRsp.data = romData;
		hostRsp.valid = lastValid && lastHost;
		hostRsp.data = romData;
	end

	// A requester seeing its response this cycle still holds valid, so mask it
	assign grantPlay = playReq.valid && !playRsp.valid;
	assign grantHost = !grantPlay && hostReq.valid && !hostRsp.valid;

	assign romAddress = grantPlay ? playReq.address : hostReq.address;

	always_ff @(posedge max10Board_50MhzClock)
	begin
		if (reset)
		begin
			lastValid <= 1'b0;
			lastHost <= 1'b0;
		end
		else
		begin
			lastValid <= grantPlay || grantHost;
			lastHost <= grantHost; // Only one grant per cycle
		end
	end

endmodule

// ==== design/playbackSequencer.sv ====
// Playback sequencer
// On each tick fetches the next sample from the ROM and hands it to the DAC serializer
// Addresses run from start to end and wrap back to start
`timescale 1ns/1ps

module playbackSequencer (
	input logic max10Board_50MhzClock,
	input logic reset,
	input logic enable,
	input logic tick,
	input audioPkg::romAddrT startAddr,
	input audioPkg::romAddrT endAddr,
	output audioPkg::romReqT romReq,
	input audioPkg::romRspT romRsp,
	output audioPkg::sampleT sample,
	output logic sampleValid,
	input logic busy,
	output audioPkg::romAddrT currentAddr,
	output logic playing
);
	import audioPkg::*;

	typedef enum logic [1:0] {stIdle, stFetch, stWait, stHand} seqStateT;

	seqStateT state;
	romAddrT lastAddr; // Effective end of the loop

	// End below start loops the start sample only
	assign lastAddr = (endAddr < startAddr) ? startAddr : endAddr;

	assign romReq.valid = (state == stFetch) || (state == stWait); // Held to the response
	assign romReq.address = currentAddr;
	assign sampleValid = (state == stHand) && !busy;

	always_ff @(posedge max10Board_50MhzClock)
	begin
		if (reset)
		begin
			state <= stIdle;
			playing <= 1'b0;
			currentAddr <= '0;
		end
		else
		begin
			case (state)
				stIdle:
				begin
					if (enable && !playing)
					begin
						playing <= 1'b1;
						currentAddr <= startAddr; // Restart on every enable
					end
					else if (!enable)
						playing <= 1'b0;
					else if (tick)
						state <= stFetch;
				end
				stFetch: state <= stWait; // Granted here, sequencer has priority
				stWait:
				begin
					if (romRsp.valid)
					begin
						sample <= romRsp.data;
						state <= stHand;
					end
				end
				stHand:
				begin
					if (!busy) // Taken this cycle
					begin
						currentAddr <= (currentAddr >= lastAddr) ? startAddr : currentAddr + 1'b1;
						state <= stIdle;
					end
				end
				default: state <= stIdle;
			endcase
		end
	end

endmodule

// ==== design/dacSpiSerializer.sv ====
// DAC SPI serializer
// Sends one sample as a 16-bit frame MSB first with SYNC_n framing
// DIN changes on SCLK rising edges, the DAC samples on falling edges
`timescale 1ns/1ps

module dacSpiSerializer (
	input logic max10Board_50MhzClock,
	input logic reset,
	input audioPkg::sampleT sample,
	input logic sampleValid,
	output logic busy,
	output logic frameDone,
	output audioPkg::spiPinsT spi
);
	import audioPkg::*;

	typedef enum logic [1:0] {stIdle, stSync, stShift, stGap} serStateT;

	serStateT state;
	dacFrameT shiftReg; // Bit 15 is on DIN
	logic [sclkCntWidth-1:0] halfCnt; // Cycles into the current SCLK half period
	logic [3:0] bitCnt; // Falling edges so far
	logic halfDone;
	logic sclkReg;
	logic syncNReg;
	logic dinReg;

	assign halfDone = (halfCnt == sclkCntWidth'(sclkHalfPeriod - 1));
	assign busy = (state != stIdle);

	always_comb
	begin
		spi.sclk = sclkReg;
		spi.syncN = syncNReg;
		spi.din = dinReg;
	end

	always_ff @(posedge max10Board_50MhzClock)
	begin
		if (reset)
		begin
			state <= stIdle;
			sclkReg <= 1'b0;
			syncNReg <= 1'b1;
			dinReg <= 1'b0;
			halfCnt <= '0;
			bitCnt <= '0;
			frameDone <= 1'b0;
		end
		else
		begin
			frameDone <= 1'b0;
			halfCnt <= halfDone ? '0 : halfCnt + 1'b1;
			case (state)
				stIdle:
				begin
					halfCnt <= '0;
					if (sampleValid)
					begin
						shiftReg <= {frameCtrlBits, sample, framePadBits};
						dinReg <= frameCtrlBits[3]; // MSB ready before first edge
						syncNReg <= 1'b0;
						bitCnt <= '0;
						state <= stSync;
					end
				end
				stSync:
				begin
					if (halfDone)
					begin
						sclkReg <= 1'b1; // First rising edge, bit 15 already out
						state <= stShift;
					end
				end
				stShift:
				begin
					if (halfDone && sclkReg)
					begin
						sclkReg <= 1'b0; // Falling edge, DAC takes the bit
						if (bitCnt == 4'd15)
							state <= stGap;
						else
							bitCnt <= bitCnt + 1'b1;
					end
					else if (halfDone)
					begin
						sclkReg <= 1'b1;
						dinReg <= shiftReg[14]; // Next bit on the rising edge
						shiftReg <= {shiftReg[14:0], 1'b0};
					end
				end
				stGap:
				begin
					if (syncNReg)
						state <= stIdle; // SYNC_n high for one cycle
					else
					begin
						syncNReg <= 1'b1;
						dinReg <= 1'b0;
						frameDone <= 1'b1; // Same cycle SYNC_n is seen high
					end
				end
				default: state <= stIdle;
			endcase
		end
	end

endmodule

// ==== design/apbControlRegs.sv ====
// APB control registers
// Control, rate, address range and status, plus a read window onto the ROM
// Window reads wait on the ROM arbiter before pready rises
`timescale 1ns/1ps

module apbControlRegs (
	input logic max10Board_50MhzClock,
	input logic reset,
	input audioPkg::apbReqT apbReq,
	output audioPkg::apbRspT apbRsp,
	output audioPkg::romReqT romReq,
	input audioPkg::romRspT romRsp,
	input audioPkg::romAddrT currentAddr,
	input logic playing,
	input logic frameDone,
	output logic enable,
	output audioPkg::rateDivT rateDiv,
	output audioPkg::romAddrT startAddr,
	output audioPkg::romAddrT endAddr
);
	import audioPkg::*;

	logic access; // Access phase of a transfer
	logic isWindow;
	logic isMapped;
	logic isReadOnly;
	logic windowRead;
	apbAddrT windowOffset;
	logic [15:0] frameCount; // Completed DAC frames

	assign access = apbReq.psel && apbReq.penable;
	assign isWindow = (apbReq.paddr >= regRomWindow); // Up to the top of the address space
	assign isReadOnly = isWindow || (apbReq.paddr == regStatus);
	assign windowRead = isWindow && !apbReq.pwrite;
	assign windowOffset = apbReq.paddr - regRomWindow;

	always_comb
	begin
		case (apbReq.paddr)
			regCtrl, regRate, regStart, regEnd, regStatus: isMapped = 1'b1;
			default: isMapped = isWindow;
		endcase
	end

	// ROM request held through the access phase
	assign romReq.valid = access && windowRead;
	assign romReq.address = romAddrT'(windowOffset >> 2); // One word per 4 bytes

	always_comb
	begin
		apbRsp.pready = access && (!windowRead || romRsp.valid);
		apbRsp.pslverr = access && (!isMapped || (apbReq.pwrite && isReadOnly));
		case (apbReq.paddr)
			regCtrl: apbRsp.prdata = apbDataT'(enable);
			regRate: apbRsp.prdata = apbDataT'(rateDiv);
			regStart: apbRsp.prdata = apbDataT'(startAddr);
			regEnd: apbRsp.prdata = apbDataT'(endAddr);
			regStatus: apbRsp.prdata = {frameCount, currentAddr, 7'b0, playing};
			default: apbRsp.prdata = isWindow ? apbDataT'(romRsp.data) : '0;
		endcase
	end

	// Register writes finish in the first access cycle
	always_ff @(posedge max10Board_50MhzClock)
	begin
		if (reset)
		begin
			enable <= 1'b0;
			rateDiv <= defaultRateDiv;
			startAddr <= '0;
			endAddr <= 8'd255;
		end
		else if (access && apbReq.pwrite)
		begin
			case (apbReq.paddr)
				regCtrl: enable <= apbReq.pwdata[0];
				regRate: rateDiv <= apbReq.pwdata[15:0];
				regStart: startAddr <= apbReq.pwdata[7:0];
				regEnd: endAddr <= apbReq.pwdata[7:0];
				default: ; // Read-only or unmapped, flagged by pslverr
			endcase
		end
	end

	always_ff @(posedge max10Board_50MhzClock)
	begin
		if (reset)
			frameCount <= '0;
		else if (frameDone)
			frameCount <= frameCount + 1'b1;
	end

endmodule

// ==== design/samplePlayerTop.sv ====
// Audio sample player top level
// Timer paces the sequencer, which streams ROM samples to the DAC over SPI
// Host configures playback and reads the ROM over APB
`timescale 1ns/1ps

module samplePlayerTop (
	input logic max10Board_50MhzClock,
	input logic reset,
	input audioPkg::apbReqT apbReq,
	output audioPkg::apbRspT apbRsp,
	output audioPkg::spiPinsT dacSpi
);
	import audioPkg::*;

	logic enable;
	logic tick;
	rateDivT rateDiv;
	romAddrT startAddr;
	romAddrT endAddr;
	romAddrT currentAddr;
	logic playing;
	romReqT playReq; // Sequencer side of the arbiter
	romRspT playRsp;
	romReqT hostReq; // Register block side
	romRspT hostRsp;
	romAddrT romAddress;
	sampleT romData;
	sampleT sample;
	logic sampleValid;
	logic busy;
	logic frameDone;

	sampleRateTimer uSampleRateTimer (
		.max10Board_50MhzClock(max10Board_50MhzClock),
		.reset(reset),
		.enable(enable),
		.rateDiv(rateDiv),
		.tick(tick)
	);

	sampleRom uSampleRom (
		.max10Board_50MhzClock(max10Board_50MhzClock),
		.address(romAddress),
		.data(romData)
	);

	romArbiter uRomArbiter (
		.max10Board_50MhzClock(max10Board_50MhzClock),
		.reset(reset),
		.playReq(playReq),
		.hostReq(hostReq),
		.playRsp(playRsp),
		.hostRsp(hostRsp),
		.romAddress(romAddress),
		.romData(romData)
	);

	playbackSequencer uPlaybackSequencer (
		.max10Board_50MhzClock(max10Board_50MhzClock),
		.reset(reset),
		.enable(enable),
		.tick(tick),
		.startAddr(startAddr),
		.endAddr(endAddr),
		.romReq(playReq),
		.romRsp(playRsp),
		.sample(sample),
		.sampleValid(sampleValid),
		.busy(busy),
		.currentAddr(currentAddr),
		.playing(playing)
	);

	dacSpiSerializer uDacSpiSerializer (
		.max10Board_50MhzClock(max10Board_50MhzClock),
		.reset(reset),
		.sample(sample),
		.sampleValid(sampleValid),
		.busy(busy),
		.frameDone(frameDone),
		.spi(dacSpi)
	);

	apbControlRegs uApbControlRegs (
		.max10Board_50MhzClock(max10Board_50MhzClock),
		.reset(reset),
		.apbReq(apbReq),
		.apbRsp(apbRsp),
		.romReq(hostReq),
		.romRsp(hostRsp),
		.currentAddr(currentAddr),
		.playing(playing),
		.frameDone(frameDone),
		.enable(enable),
		.rateDiv(rateDiv),
		.startAddr(startAddr),
		.endAddr(endAddr)
	);

endmodule

// ==== dv/samplePlayerTb.sv ====
// Audio sample player testbench
// Drives APB accesses, captures DAC SPI frames and checks them against a triangle model
`timescale 1ns/1ps

module samplePlayerTb;
	import audioPkg::*;

	localparam int timeoutCycles = 60000; // Sum of test lengths with margin

	logic max10Board_50MhzClock;
	logic reset;
	apbReqT apbReq;
	apbRspT apbRsp;
	spiPinsT dacSpi;

	dacFrameT frameQ [$]; // Captured frames waiting for the checker
	int capturedFrames = 0;
	int checkedFrames = 0;
	int errorCount = 0;
	int cycleCount = 0;
	integer seed;
	int modelStart; // Address range of the model pointer
	int modelEnd;
	int modelPtr;

	logic lastSclk = 1'b0; // SCLK one cycle back
	dacFrameT shiftIn = '0;
	int bitsIn = 0;

	samplePlayerTop u_samplePlayerTop (
		.max10Board_50MhzClock(max10Board_50MhzClock),
		.reset(reset),
		.apbReq(apbReq),
		.apbRsp(apbRsp),
		.dacSpi(dacSpi)
	);

	initial max10Board_50MhzClock = 1'b0;
	always #2 max10Board_50MhzClock = ~max10Board_50MhzClock; // 4 ns period

	// Triangle table rising then falling
	function automatic sampleT refSample(int address);
		int value;
		if (address < 128)
			value = 2 * address;
		else
			value = 2 * (255 - address);
		return sampleT'(value);
	endfunction

	// Zero control nibble, sample, zero padding
	function automatic dacFrameT refFrame(sampleT s);
		return {4'h0, s, 4'h0};
	endfunction

	task automatic checkValue(string what, logic [31:0] actual, logic [31:0] expected);
		if (actual !== expected)
		begin
			errorCount++;
			$display("[ERROR] %0t: %s, got 0x%0h, expected 0x%0h", $time, what, actual, expected);
			$display("Test failures found");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	task automatic waitCycles(int n);
		repeat (n) @(posedge max10Board_50MhzClock);
		#1;
	endtask

	// One APB transfer from setup through access until pready
	task automatic apbAccess(logic write, apbAddrT addr, apbDataT wdata,
		output apbDataT rdata, output logic err);
		apbReq.psel = 1'b1;
		apbReq.penable = 1'b0;
		apbReq.pwrite = write;
		apbReq.paddr = addr;
		apbReq.pwdata = wdata;
		@(posedge max10Board_50MhzClock);
		#1;
		apbReq.penable = 1'b1;
		do
			@(posedge max10Board_50MhzClock);
		while (!apbRsp.pready); // Window reads stretch here
		rdata = apbRsp.prdata;
		err = apbRsp.pslverr;
		#1;
		apbReq.psel = 1'b0;
		apbReq.penable = 1'b0;
	endtask

	task automatic writeReg(apbAddrT addr, apbDataT data);
		apbDataT rdata;
		logic err;
		apbAccess(1'b1, addr, data, rdata, err);
		checkValue($sformatf("pslverr on write to 0x%0h", addr), 32'(err), 32'd0);
	endtask

	task automatic expectRead(apbAddrT addr, apbDataT expected, string what);
		apbDataT rdata;
		logic err;
		apbAccess(1'b0, addr, '0, rdata, err);
		checkValue($sformatf("%s pslverr", what), 32'(err), 32'd0);
		checkValue(what, rdata, expected);
	endtask

	task automatic expectSlvErr(logic write, apbAddrT addr, string what);
		apbDataT rdata;
		logic err;
		apbAccess(write, addr, 32'h5a, rdata, err);
		checkValue(what, 32'(err), 32'd1);
	endtask

	task automatic waitFrames(int n);
		int target;
		target = checkedFrames + n;
		while (checkedFrames < target)
			@(posedge max10Board_50MhzClock);
		#1;
	endtask

	// Steady playback completes one frame per tick period
	task automatic checkFramePeriod(int expected);
		int framesSeen;
		int startCycle;
		framesSeen = capturedFrames;
		while (capturedFrames == framesSeen)
			@(posedge max10Board_50MhzClock);
		startCycle = cycleCount;
		framesSeen = capturedFrames;
		while (capturedFrames == framesSeen)
			@(posedge max10Board_50MhzClock);
		checkValue("cycles between frames", 32'(cycleCount - startCycle), 32'(expected));
		#1;
	endtask

	task automatic startPlayback(int startAddr, int endAddr);
		writeReg(regStart, apbDataT'(startAddr));
		writeReg(regEnd, apbDataT'(endAddr));
		modelStart = startAddr;
		modelEnd = endAddr;
		modelPtr = startAddr; // Every enable restarts at start
		writeReg(regCtrl, 32'd1);
	endtask

	// Clear enable and let the last frame drain
	task automatic stopPlayback();
		apbDataT rdata;
		logic err;
		writeReg(regCtrl, 32'd0);
		do
			apbAccess(1'b0, regStatus, '0, rdata, err);
		while (rdata[0]);
		while (!dacSpi.syncN)
			@(posedge max10Board_50MhzClock);
		waitCycles(4);
		while (checkedFrames != capturedFrames)
			@(posedge max10Board_50MhzClock);
		#1;
	endtask

	always @(posedge max10Board_50MhzClock)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= timeoutCycles)
		begin
			$display("Simulation timed out after %0d cycles without finishing", cycleCount);
			$display("Test failures found");
			$fatal(1, "Timeout");
		end
	end

	// DIN taken where SCLK fell with SYNC_n low
	always @(posedge max10Board_50MhzClock)
	begin
		lastSclk <= dacSpi.sclk;
		if (reset)
			bitsIn <= 0;
		else if (lastSclk && !dacSpi.sclk && !dacSpi.syncN)
		begin
			if (bitsIn == 15)
			begin
				frameQ.push_back({shiftIn[14:0], dacSpi.din}); // 16th bit completes the frame
				capturedFrames <= capturedFrames + 1;
				bitsIn <= 0;
			end
			else
			begin
				shiftIn <= {shiftIn[14:0], dacSpi.din}; // MSB first
				bitsIn <= bitsIn + 1;
			end
		end
	end

	// Frame checker against the model pointer
	initial
	begin
		dacFrameT got;
		forever
		begin
			@(posedge max10Board_50MhzClock);
			while (frameQ.size() > 0)
			begin
				got = frameQ.pop_front();
				checkValue("frame control bits", 32'(got[15:12]), 32'd0);
				checkValue("frame padding", 32'(got[3:0]), 32'd0);
				checkValue($sformatf("frame for address %0d", modelPtr), 32'(got),
					32'(refFrame(refSample(modelPtr))));
				// End below start keeps playing the start sample
				if (modelEnd < modelStart || modelPtr == modelEnd)
					modelPtr = modelStart;
				else
					modelPtr++;
				checkedFrames++;
			end
		end
	end

	initial
	begin
		apbDataT rdata;
		logic err;
		int winAddr;
		int framesBefore;
		seed = 22933;
		reset = 1'b1;
		apbReq = '0;
		repeat (5) @(posedge max10Board_50MhzClock);
		#1;
		reset = 1'b0;

		// Reset values and silence before enable
		checkValue("SYNC_n after reset", 32'(dacSpi.syncN), 32'd1);
		checkValue("SCLK after reset", 32'(dacSpi.sclk), 32'd0);
		checkValue("DIN after reset", 32'(dacSpi.din), 32'd0);
		checkValue("pready after reset", 32'(apbRsp.pready), 32'd0);
		expectRead(regCtrl, 32'd0, "ctrl reset value");
		expectRead(regRate, 32'd1041, "rate reset value");
		expectRead(regStart, 32'd0, "start reset value");
		expectRead(regEnd, 32'd255, "end reset value");
		expectRead(regStatus, 32'd0, "status reset value");
		waitCycles(200);
		checkValue("frames before enable", 32'(capturedFrames), 32'd0);

		// Register readback and slave errors
		writeReg(regRate, 32'd4660);
		expectRead(regRate, 32'd4660, "rate readback");
		writeReg(regStart, 32'd33);
		expectRead(regStart, 32'd33, "start readback");
		writeReg(regEnd, 32'd77);
		expectRead(regEnd, 32'd77, "end readback");
		expectSlvErr(1'b1, regStatus, "pslverr on status write");
		expectSlvErr(1'b0, 8'h14, "pslverr on unmapped read");
		expectSlvErr(1'b1, 8'h18, "pslverr on unmapped write");
		expectSlvErr(1'b1, 8'h24, "pslverr on window write");

		repeat (20)
		begin
			winAddr = {$random(seed)} % 56; // Window reaches address 55
			expectRead(apbAddrT'(32 + 4 * winAddr), apbDataT'(refSample(winAddr)), "ROM window read");
		end

		// End below start loops the start sample
		writeReg(regRate, 32'd100);
		startPlayback(250, 5);
		waitFrames(4);
		stopPlayback();
		startPlayback(10, 14);
		waitFrames(12);
		checkFramePeriod(100 + 1); // One tick every rateDiv+1 cycles

		// Host reads compete with sequencer fetches
		apbAccess(1'b0, regStatus, '0, rdata, err);
		checkValue("playing during playback", 32'(rdata[0]), 32'd1);
		repeat (100)
		begin
			winAddr = {$random(seed)} % 56;
			expectRead(apbAddrT'(32 + 4 * winAddr), apbDataT'(refSample(winAddr)),
				"ROM window read during playback");
		end
		waitFrames(5);

		// Disable lets the current frame finish before silence
		stopPlayback();
		framesBefore = capturedFrames;
		waitCycles(400);
		checkValue("frames after disable", 32'(capturedFrames), 32'(framesBefore));
		apbAccess(1'b0, regStatus, '0, rdata, err);
		checkValue("status frame count", 32'(rdata[31:16]), 32'(capturedFrames));
		checkValue("status current address", 32'(rdata[15:8]), 32'(modelPtr)); // Next to play
		checkValue("status reserved bits", 32'(rdata[7:1]), 32'd0);
		checkValue("status playing after disable", 32'(rdata[0]), 32'd0);

		if (errorCount == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// ==== sim.f ====
design/audioPkg.sv
design/sampleRateTimer.sv
design/sampleRom.sv
design/romArbiter.sv
design/playbackSequencer.sv
design/dacSpiSerializer.sv
design/apbControlRegs.sv
design/samplePlayerTop.sv
dv/samplePlayerTb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the sample player testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f sim.f --top-module samplePlayerTb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/VsamplePlayerTb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "All tests passed!"; then
	echo "Simulation PASSED"
	exit 0
fi

echo "Simulation FAILED"
exit 1
